//--- hdl/timer_cfg.svh
`ifndef TIMER_CFG_SVH
`define TIMER_CFG_SVH

`define TM_WIDTH      32  // Counter and data path width
`define PWM_CHANNELS  2   // Compare and PWM channels
`define HADDR_W       32
`define REG_AW        6   // Word address bits inside the block

// Hold counts per 2-bit filter code
`define FILT_LEN0     0
`define FILT_LEN1     3
`define FILT_LEN2     5
`define FILT_LEN3     7

`define A_TMVAL       6'd0
`define A_TMPR        6'd1
`define A_TMPRSH      6'd2
`define A_TMCAP0      6'd3
`define A_TMCAP1      6'd4
`define A_TRS         6'd5   // Bit 0 run set, bit 1 run clear, bit 2 timer clear
`define A_TCFS        6'd6
`define A_TRST        6'd7
`define A_TMS         6'd8
`define A_ECR         6'd9
`define A_CMC         6'd10
`define A_ISR         6'd11
`define A_IEC         6'd12
`define A_ISC         6'd13
`define A_PLC         6'd14
`define A_TMCMP       6'd16  // Compare then shadow, two words per channel

`endif

//--- hdl/timerPkg.sv
`default_nettype none

package timerPkg;

  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_BUSY   = 2'b01;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  typedef logic [1:0] evSel;  // 0 none, 1 to 3 pick event 0 to 2

  typedef enum logic [1:0] {
    EDGE_NONE,
    EDGE_RISE,
    EDGE_FALL,
    EDGE_BOTH
  } edgeMode;

  typedef struct packed {
    evSel capSel;
    evSel cntSel;
    evSel stopSel;
    evSel startSel;
  } cmcReg;

  typedef struct packed {
    logic capChain;
    logic stopClears;
    logic startClears;
    logic centerAligned;
  } tmsReg;

  typedef struct packed {
    logic       lowActive;
    edgeMode    edgeSel;
    logic [1:0] filtCode;
  } evCfg;

  typedef evCfg [2:0] ecrReg;  // Event 0 in the low bits

  typedef struct packed {
    logic ev0Detect;
    logic cmpMatchUp;
    logic periodMatchUp;
  } intReg;

endpackage

`default_nettype wire

//--- hdl/ahbRegFile.sv
`include "timer_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module ahbRegFile #(
  parameter logic [`HADDR_W-1:0] BASE_ADDR = '0
) (
  input  wire                                     CPUbus,
  input  wire                                     arstN,
  input  wire                                     hSel,
  input  wire [`HADDR_W-1:0]                      hAddr,
  input  wire [1:0]                               hTrans,
  input  wire                                     hWrite,
  input  wire [`TM_WIDTH-1:0]                     hWdata,
  input  wire                                     hReady,
  input  wire [`TM_WIDTH-1:0]                     timerValue,
  input  wire                                     running,
  input  wire                                     countDown,
  input  wire                                     periodMatch,
  input  wire [`PWM_CHANNELS-1:0]                 cmpMatch,
  input  wire                                     shadowXfer,
  input  wire                                     evEdge0,
  input  wire [`TM_WIDTH-1:0]                     cap0,
  input  wire [`TM_WIDTH-1:0]                     cap1,
  input  wire [1:0]                               capFull,
  output logic [`TM_WIDTH-1:0]                    hRdata,
  output logic                                    hReadyOut,
  output logic                                    hResp,
  output logic [`TM_WIDTH-1:0]                    period,
  output logic [`PWM_CHANNELS-1:0][`TM_WIDTH-1:0] compare,
  output timerPkg::cmcReg                         cmc,
  output timerPkg::tmsReg                         tms,
  output timerPkg::ecrReg                         ecr,
  output logic [`PWM_CHANNELS-1:0]                polarity,
  output logic                                    runSet,
  output logic                                    runClear,
  output logic                                    swClear,
  output logic                                    cap0Read,
  output logic                                    cap1Read,
  output logic                                    intr
);

  logic                                    accept;
  logic                                    wrEn;
  logic                                    rdEn;
  logic [`REG_AW-1:0]                      regAddr;
  logic [`HADDR_W-1:0]                     addrOff;
  logic [`TM_WIDTH-1:0]                    periodSh;
  logic [`PWM_CHANNELS-1:0][`TM_WIDTH-1:0] compareSh;
  timerPkg::intReg                         isr;
  timerPkg::intReg                         iec;
  timerPkg::intReg                         intSet;
  timerPkg::intReg                         intClr;

  function automatic logic [`REG_AW-1:0] cmpAddr(input int ch);
    return `A_TMCMP + `REG_AW'(2 * ch);
  endfunction

  assign accept = hSel && hReady &&
                  (hTrans == timerPkg::HTRANS_NONSEQ || hTrans == timerPkg::HTRANS_SEQ);
  assign addrOff   = hAddr - BASE_ADDR;
  assign hReadyOut = 1'b1;  // Zero wait states
  assign hResp     = 1'b0;  // Always OKAY

  always_ff @(posedge CPUbus or negedge arstN) begin
    if (!arstN) begin
      wrEn    <= 1'b0;
      rdEn    <= 1'b0;
      regAddr <= '0;
    end else if (hReady) begin
      wrEn    <= accept && hWrite;
      rdEn    <= accept && !hWrite;
      regAddr <= addrOff[`REG_AW+1:2];
    end
  end

  // Strobes act at the edge ending the data phase
  assign runSet   = wrEn && regAddr == `A_TRS && hWdata[0];
  assign runClear = wrEn && regAddr == `A_TRS && hWdata[1];
  assign swClear  = wrEn && regAddr == `A_TRS && hWdata[2];
  assign cap0Read = rdEn && regAddr == `A_TMCAP0;
  assign cap1Read = rdEn && regAddr == `A_TMCAP1;

  always_ff @(posedge CPUbus or negedge arstN) begin
    if (!arstN) begin
      period    <= '0;
      periodSh  <= '0;
      compare   <= '0;
      compareSh <= '0;
      cmc       <= '0;
      tms       <= '0;
      ecr       <= '0;
      iec       <= '0;
      polarity  <= '0;
    end else begin
      if (wrEn && (regAddr == `A_TMPR || (regAddr == `A_TMPRSH && !running))) begin
        period <= hWdata;  // Shadow writes go straight through while stopped
      end else if (running && shadowXfer) begin
        period <= periodSh;
      end
      if (wrEn && regAddr == `A_TMPRSH) periodSh <= hWdata;
      for (int i = 0; i < `PWM_CHANNELS; i++) begin
        if (wrEn && (regAddr == cmpAddr(i) ||
                     (regAddr == cmpAddr(i) + 1'b1 && !running))) begin
          compare[i] <= hWdata;
        end else if (running && shadowXfer) begin
          compare[i] <= compareSh[i];
        end
        if (wrEn && regAddr == cmpAddr(i) + 1'b1) compareSh[i] <= hWdata;
      end
      if (wrEn && regAddr == `A_CMC) cmc <= hWdata[$bits(cmc)-1:0];
      if (wrEn && regAddr == `A_TMS) tms <= hWdata[$bits(tms)-1:0];
      if (wrEn && regAddr == `A_ECR) ecr <= hWdata[$bits(ecr)-1:0];
      if (wrEn && regAddr == `A_IEC) iec <= hWdata[$bits(iec)-1:0];
      if (wrEn && regAddr == `A_PLC) polarity <= hWdata[`PWM_CHANNELS-1:0];
    end
  end

  assign intSet.periodMatchUp = running && periodMatch && !countDown;
  assign intSet.cmpMatchUp    = running && (|cmpMatch) && !countDown;
  assign intSet.ev0Detect     = evEdge0;
  assign intClr = (wrEn && regAddr == `A_ISC) ? hWdata[$bits(intClr)-1:0] : '0;

  always_ff @(posedge CPUbus or negedge arstN) begin
    if (!arstN) begin
      isr <= '0;
    end else begin
      isr <= (isr & ~intClr) | (intSet & iec);  // Set beats clear
    end
  end

  assign intr = |isr;

  always_comb begin
    hRdata = '0;
    case (regAddr)
      `A_TMVAL:  hRdata = timerValue;
      `A_TMPR:   hRdata = period;
      `A_TMPRSH: hRdata = periodSh;
      `A_TMCAP0: hRdata = cap0;
      `A_TMCAP1: hRdata = cap1;
      `A_TCFS:   hRdata[1:0] = capFull;
      `A_TRST:   hRdata[1:0] = {countDown, running};
      `A_TMS:    hRdata[$bits(tms)-1:0] = tms;
      `A_ECR:    hRdata[$bits(ecr)-1:0] = ecr;
      `A_CMC:    hRdata[$bits(cmc)-1:0] = cmc;
      `A_ISR:    hRdata[$bits(isr)-1:0] = isr;
      `A_IEC:    hRdata[$bits(iec)-1:0] = iec;
      `A_PLC:    hRdata[`PWM_CHANNELS-1:0] = polarity;
      default: begin
        for (int i = 0; i < `PWM_CHANNELS; i++) begin
          if (regAddr == cmpAddr(i)) hRdata = compare[i];
          if (regAddr == cmpAddr(i) + 1'b1) hRdata = compareSh[i];
        end
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/eventConditioner.sv
`include "timer_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module eventConditioner (
  input  wire               CPUbus,
  input  wire               arstN,
  input  wire               evIn,
  input  wire [1:0]         filtCode,
  input  timerPkg::edgeMode edgeSel,
  input  wire               lowActive,
  output logic              evEdge,
  output logic              evLevel
);

  logic [2:0] holdLen;
  logic [2:0] holdCnt;
  logic       evFilt;
  logic       evFiltDly;
  logic       rise;
  logic       fall;

  always_comb begin
    case (filtCode)
      2'd0:    holdLen = 3'(`FILT_LEN0);
      2'd1:    holdLen = 3'(`FILT_LEN1);
      2'd2:    holdLen = 3'(`FILT_LEN2);
      default: holdLen = 3'(`FILT_LEN3);
    endcase
  end

  assign rise = evFilt && !evFiltDly;
  assign fall = !evFilt && evFiltDly;

  always_ff @(posedge CPUbus or negedge arstN) begin
    if (!arstN) begin
      holdCnt   <= '0;
      evFilt    <= 1'b0;
      evFiltDly <= 1'b0;
      evEdge    <= 1'b0;
      evLevel   <= 1'b0;
    end else begin
      if (evIn == evFilt) begin
        holdCnt <= '0;  // Glitch gone, start over
      end else if (holdCnt == holdLen) begin
        evFilt  <= evIn;
        holdCnt <= '0;
      end else begin
        holdCnt <= holdCnt + 3'd1;
      end
      evFiltDly <= evFilt;
      case (edgeSel)
        timerPkg::EDGE_RISE: evEdge <= rise;
        timerPkg::EDGE_FALL: evEdge <= fall;
        timerPkg::EDGE_BOTH: evEdge <= rise || fall;
        default:             evEdge <= 1'b0;
      endcase
      evLevel <= evFilt ^ lowActive;  // Active-low option
    end
  end

endmodule

`default_nettype wire

//--- hdl/timerCore.sv
`include "timer_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module timerCore (
  input  wire                                     CPUbus,
  input  wire                                     arstN,
  input  wire [`TM_WIDTH-1:0]                     period,
  input  wire [`PWM_CHANNELS-1:0][`TM_WIDTH-1:0]  compare0,  // All channels, channel 0 lowest
  input  timerPkg::cmcReg                         cmc,
  input  timerPkg::tmsReg                         tms,
  input  wire [2:0]                               evEdge,
  input  wire                                     runSet,
  input  wire                                     runClear,
  input  wire                                     swClear,
  input  wire                                     cap0Read,
  input  wire                                     cap1Read,
  output logic [`TM_WIDTH-1:0]                    timerValue,
  output logic                                    running,
  output logic                                    countDown,
  output logic                                    periodMatch,
  output logic                                    zeroMatch,
  output logic [`PWM_CHANNELS-1:0]                cmpMatch,
  output logic                                    shadowXfer,
  output logic                                    countEnable,
  output logic [`TM_WIDTH-1:0]                    cap0,
  output logic [`TM_WIDTH-1:0]                    cap1,
  output logic [1:0]                              capFull
);

  logic evStart;
  logic evStop;
  logic evCount;
  logic evCapture;
  logic startReq;
  logic stopReq;
  logic timerClear;
  logic cap1Wr;

  function automatic logic pickEvent(input timerPkg::evSel sel, input logic [2:0] ev);
    return (sel == 2'd0) ? 1'b0 : ev[sel - 2'd1];
  endfunction

  assign evStart   = pickEvent(cmc.startSel, evEdge);
  assign evStop    = pickEvent(cmc.stopSel, evEdge);
  assign evCount   = pickEvent(cmc.cntSel, evEdge);
  assign evCapture = pickEvent(cmc.capSel, evEdge);

  assign startReq    = runSet || evStart;
  assign stopReq     = runClear || evStop;
  assign timerClear  = swClear || (startReq && tms.startClears) || (stopReq && tms.stopClears);
  assign countEnable = (cmc.cntSel == 2'd0) || evCount;  // Free running unless a source is picked

  assign periodMatch = timerValue == period;
  assign zeroMatch   = timerValue == '0;
  assign shadowXfer  = (periodMatch && !countDown) || (zeroMatch && countDown) || !running;
  assign cap1Wr      = evCapture && (tms.capChain || capFull[0]);

  always_comb begin
    for (int i = 0; i < `PWM_CHANNELS; i++) begin
      cmpMatch[i] = timerValue == compare0[i];
    end
  end

  always_ff @(posedge CPUbus or negedge arstN) begin
    if (!arstN) begin
      running    <= 1'b0;
      timerValue <= '0;
      countDown  <= 1'b0;
      capFull    <= '0;
    end else begin
      if (startReq) begin
        running <= 1'b1;
      end else if (stopReq) begin
        running <= 1'b0;
      end
      if (timerClear) begin
        timerValue <= '0;
        countDown  <= 1'b0;
      end else if (running && countEnable) begin
        if (!tms.centerAligned) begin
          countDown  <= 1'b0;
          timerValue <= (timerValue >= period) ? '0 : timerValue + 1'b1;  // Wrap at period
        end else if (countDown) begin
          if (zeroMatch) begin
            countDown  <= 1'b0;
            timerValue <= timerValue + 1'b1;
          end else begin
            timerValue <= timerValue - 1'b1;
          end
        end else if (timerValue >= period) begin
          countDown  <= 1'b1;  // Turn around at the top
          timerValue <= timerValue - 1'b1;
        end else begin
          timerValue <= timerValue + 1'b1;
        end
      end
      if (evCapture) begin
        capFull[0] <= 1'b1;
      end else if (cap0Read) begin
        capFull[0] <= 1'b0;
      end
      if (cap1Wr) begin
        capFull[1] <= 1'b1;
      end else if (cap1Read) begin
        capFull[1] <= 1'b0;
      end
    end
  end

  always_ff @(posedge CPUbus) begin
    if (evCapture) cap0 <= timerValue;
    if (cap1Wr) cap1 <= cap0;  // Older capture slides down
  end

  assertEdgeRange: assert property (@(posedge CPUbus) disable iff (!arstN)
    running && !tms.centerAligned && $stable(period) |-> timerValue <= period);

  assertFull0Hold: assert property (@(posedge CPUbus) disable iff (!arstN)
    $fell(capFull[0]) |-> $past(cap0Read));

  assertFull1Hold: assert property (@(posedge CPUbus) disable iff (!arstN)
    $fell(capFull[1]) |-> $past(cap1Read));

endmodule

`default_nettype wire

//--- hdl/pwmGen.sv
`include "timer_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module pwmGen (
  input  wire                                     CPUbus,
  input  wire                                     arstN,
  input  wire                                     running,
  input  wire                                     countDown,
  input  wire                                     centerAligned,
  input  wire                                     countEnable,
  input  wire [`TM_WIDTH-1:0]                     timerValue,
  input  wire [`PWM_CHANNELS-1:0][`TM_WIDTH-1:0]  compare,
  input  wire [`PWM_CHANNELS-1:0]                 cmpMatch,
  input  wire                                     zeroMatch,
  input  wire                                     periodMatch,
  input  wire [`PWM_CHANNELS-1:0]                 polarity,
  output logic [`PWM_CHANNELS-1:0]                pwm
);

  logic [`PWM_CHANNELS-1:0] pwmState;

  always_ff @(posedge CPUbus or negedge arstN) begin
    if (!arstN) begin
      pwmState <= '0;
    end else begin
      for (int i = 0; i < `PWM_CHANNELS; i++) begin
        if (!running) begin
          pwmState[i] <= timerValue > compare[i];  // Static level while stopped
        end else if (countEnable) begin
          if (centerAligned) begin
            if (cmpMatch[i]) begin
              pwmState[i] <= !pwmState[i];
            end else if (zeroMatch && countDown) begin
              pwmState[i] <= 1'b0;
            end
          end else if (cmpMatch[i]) begin
            pwmState[i] <= 1'b1;
          end else if (periodMatch) begin
            pwmState[i] <= 1'b0;
          end
        end
      end
    end
  end

  assign pwm = pwmState ^ polarity;  // Passive level inversion

endmodule

`default_nettype wire

//--- hdl/timerTop.sv
`include "timer_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module timerTop (
  input  wire                       CPUbus,
  input  wire                       arstN,
  input  wire                       hSel,
  input  wire [`HADDR_W-1:0]        hAddr,
  input  wire [1:0]                 hTrans,
  input  wire                       hWrite,
  input  wire [`TM_WIDTH-1:0]       hWdata,
  input  wire                       hReady,
  input  wire [2:0]                 evnt,
  output logic [`TM_WIDTH-1:0]      hRdata,
  output logic                      hReadyOut,
  output logic                      hResp,
  output logic [`PWM_CHANNELS-1:0]  pwm,
  output logic                      intr
);

  logic [`TM_WIDTH-1:0]                    period;
  logic [`PWM_CHANNELS-1:0][`TM_WIDTH-1:0] compare;
  timerPkg::cmcReg                         cmc;
  timerPkg::tmsReg                         tms;
  timerPkg::ecrReg                         ecr;
  logic [`PWM_CHANNELS-1:0]                polarity;
  logic                                    runSet;
  logic                                    runClear;
  logic                                    swClear;
  logic                                    cap0Read;
  logic                                    cap1Read;
  logic [2:0]                              evEdge;
  logic [`TM_WIDTH-1:0]                    timerValue;
  logic                                    running;
  logic                                    countDown;
  logic                                    periodMatch;
  logic                                    zeroMatch;
  logic [`PWM_CHANNELS-1:0]                cmpMatch;
  logic                                    shadowXfer;
  logic                                    countEnable;
  logic [`TM_WIDTH-1:0]                    cap0;
  logic [`TM_WIDTH-1:0]                    cap1;
  logic [1:0]                              capFull;

  ahbRegFile i_regFile (
    .evEdge0(evEdge[0]),
    .*
  );

  for (genvar g = 0; g < 3; g++) begin : genEvent
    eventConditioner i_evCond (
      .CPUbus,
      .arstN,
      .evIn(evnt[g]),
      .filtCode(ecr[g].filtCode),
      .edgeSel(ecr[g].edgeSel),
      .lowActive(ecr[g].lowActive),
      .evEdge(evEdge[g]),
      .evLevel()  // No level consumers in this timer
    );
  end

  timerCore i_core (
    .compare0(compare),
    .*
  );

  pwmGen i_pwm (
    .centerAligned(tms.centerAligned),
    .*
  );

endmodule

`default_nettype wire

//--- bench/timerTb.sv
`include "timer_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module timerTb;

  localparam int P_RUN      = 15;  // Period for the counting tests
  localparam int P_PWM      = 9;
  localparam int C_PWM      = 3;
  localparam int READY_WAIT = 16;

  logic                      CPUbus;
  logic                      arstN;
  logic                      hSel;
  logic [`HADDR_W-1:0]       hAddr;
  logic [1:0]                hTrans;
  logic                      hWrite;
  logic [`TM_WIDTH-1:0]      hWdata;
  logic                      hReady;
  logic [2:0]                evnt;
  wire  [`TM_WIDTH-1:0]      hRdata;
  wire                       hReadyOut;
  wire                       hResp;
  wire  [`PWM_CHANNELS-1:0]  pwm;
  wire                       intr;

  integer seed;
  int     errCount;
  int     testCount;
  int     testErrBase;
  string  curTest;

  timerTop i_timerTop (.*);

  initial CPUbus = 1'b0;
  always #50 CPUbus = ~CPUbus;  // 100 ns period

  task automatic expectEqual(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("MISMATCH %s: %s expected 0x%08h actual 0x%08h", curTest, what, exp, act);
      errCount++;
    end
  endtask

  task automatic expectAtMost(input string what, input logic [31:0] limit,
                              input logic [31:0] act);
    assert (act <= limit) else begin
      $display("MISMATCH %s: %s expected at most 0x%08h actual 0x%08h",
               curTest, what, limit, act);
      errCount++;
    end
  endtask

  task automatic reportFailure(input string msg);
    $display("ERROR %s: %s", curTest, msg);
    errCount++;
  endtask

  task automatic startTest(input string name);
    curTest     = name;
    testErrBase = errCount;
    testCount++;
  endtask

  task automatic endTest;
    $display("test %0d %s: %0d error(s)", testCount, curTest, errCount - testErrBase);
  endtask

  task automatic waitCycles(input int n);
    repeat (n) @(negedge CPUbus);
  endtask

  task automatic waitReady;
    int n;
    n = 0;
    while (!hReadyOut && n < READY_WAIT) begin
      @(negedge CPUbus);
      n++;
    end
    assert (hReadyOut) else reportFailure("slave held hReadyOut low past the timeout");
  endtask

  task automatic driveAddress(input logic [`REG_AW-1:0] word, input logic write);
    @(negedge CPUbus);
    hSel                = 1'b1;
    hAddr               = '0;
    hAddr[`REG_AW+1:2]  = word;  // Word address, byte lanes zero
    hTrans              = timerPkg::HTRANS_NONSEQ;
    hWrite              = write;
  endtask

  task automatic busWrite(input logic [`REG_AW-1:0] word, input logic [31:0] data);
    driveAddress(word, 1'b1);
    @(negedge CPUbus);
    hSel   = 1'b0;
    hTrans = timerPkg::HTRANS_IDLE;
    hWrite = 1'b0;
    hWdata = data;  // Held until the next data phase
    waitReady();
    expectEqual("hResp", 32'h0, {31'd0, hResp});
  endtask

  task automatic busRead(input logic [`REG_AW-1:0] word, output logic [31:0] data);
    driveAddress(word, 1'b0);
    @(negedge CPUbus);
    hSel   = 1'b0;
    hTrans = timerPkg::HTRANS_IDLE;
    waitReady();
    data = hRdata;
    expectEqual("hResp", 32'h0, {31'd0, hResp});
  endtask

  task automatic countHigh(input int cycles, output int cnt);
    cnt = 0;
    repeat (cycles) begin
      @(negedge CPUbus);
      if (pwm[0]) cnt++;
    end
  endtask

  task automatic pulseEvent(input int len);
    @(negedge CPUbus);
    evnt[0] = 1'b1;
    waitCycles(len);
    evnt[0] = 1'b0;
  endtask

  task automatic checkStoppedPwm(input logic [31:0] value, input logic [31:0] cmp);
    busWrite(`A_TMCMP, cmp);
    waitCycles(2);  // Compare register, then PWM state
    expectEqual("pwm[0] while stopped", {31'd0, value > cmp}, {31'd0, pwm[0]});
  endtask

  task automatic testRegAccess;
    logic [31:0] perVal;
    logic [31:0] shVal;
    logic [31:0] cmpVal;
    logic [31:0] cmpShVal;
    logic [31:0] cmcVal;
    logic [31:0] tmsVal;
    logic [31:0] ecrVal;
    logic [31:0] got;
    startTest("register access");
    expectEqual("intr after reset", 32'h0, {31'd0, intr});
    expectEqual("pwm after reset", 32'h0, {30'd0, pwm});
    perVal   = $random(seed);
    shVal    = $random(seed);
    cmpVal   = $random(seed);
    cmpShVal = $random(seed);
    cmcVal   = $random(seed) & 32'h0000_00ff;  // Four 2-bit selects
    tmsVal   = $random(seed) & 32'h0000_000f;
    ecrVal   = $random(seed) & 32'h0000_7fff;  // Three 5-bit event fields
    busWrite(`A_TMPR, perVal);
    busRead(`A_TMPR, got);
    expectEqual("TMPR", perVal, got);
    busWrite(`A_TMPRSH, shVal);
    busRead(`A_TMPRSH, got);
    expectEqual("TMPRSH", shVal, got);
    busRead(`A_TMPR, got);
    expectEqual("TMPR after stopped shadow write", shVal, got);
    busWrite(`A_TMCMP, cmpVal);
    busRead(`A_TMCMP, got);
    expectEqual("TMCMP0", cmpVal, got);
    busWrite(`A_TMCMP + 6'd1, cmpShVal);
    busRead(`A_TMCMP + 6'd1, got);
    expectEqual("TMCMP0 shadow", cmpShVal, got);
    busRead(`A_TMCMP, got);
    expectEqual("TMCMP0 after stopped shadow write", cmpShVal, got);
    busWrite(`A_CMC, cmcVal);
    busRead(`A_CMC, got);
    expectEqual("CMC", cmcVal, got);
    busWrite(`A_TMS, tmsVal);
    busRead(`A_TMS, got);
    expectEqual("TMS", tmsVal, got);
    busWrite(`A_ECR, ecrVal);
    busRead(`A_ECR, got);
    expectEqual("ECR", ecrVal, got);
    busWrite(`A_CMC, 32'h0);  // Back to software control
    busWrite(`A_TMS, 32'h0);
    busWrite(`A_ECR, 32'h0);
    endTest();
  endtask

  task automatic testEdgeCount;
    logic [31:0] got;
    int          n;
    startTest("edge-aligned count and period interrupt");
    busWrite(`A_TMPRSH, P_RUN);  // Live period follows while stopped
    busWrite(`A_IEC, 32'h1);
    busWrite(`A_ISC, 32'h7);
    busWrite(`A_TRS, 32'h5);  // Run and clear
    n = 0;
    while (!intr && n < 50) begin
      busRead(`A_TMVAL, got);
      expectAtMost("TMVAL", P_RUN, got);
      n++;
    end
    assert (intr) else reportFailure("period interrupt did not rise before the timeout");
    busWrite(`A_ISC, 32'h1);
    busRead(`A_ISR, got);
    expectEqual("ISR after clear", 32'h0, got);
    expectEqual("intr after clear", 32'h0, {31'd0, intr});
    n = 0;
    while (!intr && n < 3 * (P_RUN + 1)) begin
      waitCycles(1);
      n++;
    end
    assert (intr) else reportFailure("period interrupt did not rise again at the next period");
    endTest();
  endtask

  task automatic testShadow;
    logic [31:0] got;
    logic [31:0] prev;
    logic [31:0] newPer;
    int          n;
    logic        wrapped;
    startTest("period shadow transfer");
    newPer = P_RUN + 8;
    n      = 0;
    busRead(`A_TMVAL, got);
    // Line up near the start of a period
    while ((got < 1 || got > 4) && n < 40) begin
      busRead(`A_TMVAL, got);
      n++;
    end
    assert (got >= 1 && got <= 4) else reportFailure("timer never reached the start of a period");
    prev = got;
    busWrite(`A_TMPRSH, newPer);
    busRead(`A_TMPR, got);
    expectEqual("TMPR before match", P_RUN, got);
    wrapped = 1'b0;
    n       = 0;
    while (!wrapped && n < 40) begin
      busRead(`A_TMVAL, got);
      if (got < prev) begin
        wrapped = 1'b1;  // Period match has passed
      end else if (got + 3 <= P_RUN) begin
        prev = got;
        busRead(`A_TMPR, got);
        expectEqual("TMPR before match", P_RUN, got);
      end else begin
        prev = got;
      end
      n++;
    end
    assert (wrapped) else reportFailure("no period match seen before the timeout");
    busRead(`A_TMPR, got);
    expectEqual("TMPR after match", newPer, got);
    endTest();
  endtask

  task automatic testPwm;
    logic [31:0] got;
    int          highCnt;
    startTest("PWM duty and polarity");
    busWrite(`A_TRS, 32'h6);  // Stop and clear
    busWrite(`A_TMPRSH, P_PWM);
    busWrite(`A_TMCMP + 6'd1, C_PWM);
    busWrite(`A_PLC, 32'h0);
    busWrite(`A_TRS, 32'h5);
    waitCycles(2 * (P_PWM + 1));  // Settle into steady periods
    countHigh(P_PWM + 1, highCnt);
    expectEqual("pwm[0] high cycles", P_PWM - C_PWM, highCnt);
    busWrite(`A_PLC, 32'h1);
    countHigh(P_PWM + 1, highCnt);
    expectEqual("inverted pwm[0] high cycles", C_PWM + 1, highCnt);
    busWrite(`A_PLC, 32'h0);
    busWrite(`A_TRS, 32'h2);  // Stop, keep the value
    busRead(`A_TMVAL, got);
    if (got > 0) checkStoppedPwm(got, got - 1);
    checkStoppedPwm(got, got);
    checkStoppedPwm(got, got + 1);
    busWrite(`A_TRS, 32'h4);
    checkStoppedPwm(32'h0, 32'h0);
    expectEqual("pwm after clear", 32'h0, {30'd0, pwm});
    endTest();
  endtask

  task automatic testEventCapture;
    logic [31:0] got;
    logic [31:0] firstCap;
    int          n;
    startTest("event filter, capture and external start");
    busWrite(`A_TRS, 32'h6);
    busWrite(`A_TMS, 32'h0);
    busWrite(`A_ECR, 32'h7);   // Event 0 filter code 3, rising edge
    busWrite(`A_CMC, 32'h41);  // Event 0 starts and captures
    busWrite(`A_IEC, 32'h0);
    busWrite(`A_ISC, 32'h7);
    pulseEvent(4);
    waitCycles(12);
    busRead(`A_TCFS, got);
    expectEqual("TCFS after short pulse", 32'h0, got);
    busRead(`A_TRST, got);
    expectEqual("run bit after short pulse", 32'h0, {31'd0, got[0]});
    pulseEvent(20);
    got = '0;
    n   = 0;
    while (!got[0] && n < 20) begin
      busRead(`A_TRST, got);
      n++;
    end
    assert (got[0]) else reportFailure("long event pulse did not start the timer");
    busRead(`A_TCFS, got);
    expectEqual("TCFS after long pulse", 32'h1, got);
    busRead(`A_TMCAP0, firstCap);
    expectEqual("CAP0 of stopped cleared timer", 32'h0, firstCap);
    busRead(`A_TCFS, got);
    expectEqual("TCFS after CAP0 read", 32'h0, got);
    busWrite(`A_TMS, 32'h8);  // Capture chaining
    busWrite(`A_IEC, 32'h4);
    pulseEvent(20);
    got = '0;
    n   = 0;
    while (got[1:0] != 2'b11 && n < 20) begin
      busRead(`A_TCFS, got);
      n++;
    end
    expectEqual("TCFS after second pulse", 32'h3, got);
    busRead(`A_TMCAP1, got);
    expectEqual("CAP1 holds first capture", firstCap, got);
    busRead(`A_TMCAP0, got);
    expectAtMost("CAP0 of running timer", P_PWM, got);
    busRead(`A_ISR, got);
    expectEqual("ISR after event", 32'h4, got);
    expectEqual("intr after event", 32'h1, {31'd0, intr});
    busWrite(`A_TRS, 32'h6);
    endTest();
  endtask

  initial begin
    seed        = 88287;
    errCount    = 0;
    testCount   = 0;
    testErrBase = 0;
    curTest     = "reset";
    hSel        = 1'b0;
    hAddr       = '0;
    hTrans      = timerPkg::HTRANS_IDLE;
    hWrite      = 1'b0;
    hWdata      = '0;
    hReady      = 1'b1;  // Single slave on the bus
    evnt        = '0;
    arstN       = 1'b0;
    waitCycles(4);
    arstN = 1'b1;
    testRegAccess();
    testEdgeCount();
    testShadow();
    testPwm();
    testEventCapture();
    $display("tests run %0d, errors %0d", testCount, errCount);
    if (errCount == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+hdl
hdl/timerPkg.sv
hdl/ahbRegFile.sv
hdl/eventConditioner.sv
hdl/timerCore.sv
hdl/pwmGen.sv
hdl/timerTop.sv
bench/timerTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= timerTb
FILELIST  ?= sources.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf $(OBJDIR)
